/* common/pmp_cfg.svh */
`ifndef PMP_CFG_SVH
`define PMP_CFG_SVH

// number of entries, multiple of 4 so cfg words are full
`define PMP_ENTRIES 8
// address and data bus width
`define PMP_XLEN 32
// minimum NAPOT granularity exponent
`define PMP_GRAN 0

// register map byte offsets
`define PMP_CFG_BASE 32'h0000_0000
`define PMP_ADDR_BASE 32'h0000_0010

`endif

/* common/pmp_pkg.sv */
`default_nettype none

package pmp_pkg;

  // address-match mode held in the A field of a cfg byte
  typedef enum logic [1:0] {
    OFF   = 2'd0,                  // entry disabled
    TOR   = 2'd1,                  // top of range, bottom is previous entry
    NA4   = 2'd2,                  // single word
    NAPOT = 2'd3                   // naturally aligned power-of-two region
  } pmp_a_e;

  // one pmpcfg byte, msb first as in the privileged spec
  typedef struct packed {
    logic       l;                 // lock, also enforces on M-mode
    logic [1:0] rsvd;              // reserved, kept as written
    pmp_a_e     a;                 // match mode
    logic       x;                 // execute allowed
    logic       w;                 // write allowed
    logic       r;                 // read allowed
  } pmp_cfg_t;

  // privilege of the checked access, RISC-V encoding
  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_M = 2'd3
  } priv_e;

  // access type opcode on the check port
  typedef enum logic [1:0] {
    ACC_READ  = 2'd0,
    ACC_WRITE = 2'd1,
    ACC_EXEC  = 2'd2
  } access_e;

  // AXI response codes used by the slave
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

endpackage

`default_nettype wire

/* design/pmp_check/pmp_matcher.sv */
`default_nettype none
`timescale 1ns/10ps
`include "pmp_cfg.svh"

module pmp_matcher (
  input  logic [`PMP_XLEN-1:0] phys_addr,        // checked address, pmpaddr units
  input  pmp_pkg::pmp_cfg_t    check_cfg,        // entry cfg byte
  input  logic [`PMP_XLEN-1:0] cfg_addr,         // this entry's pmpaddr
  input  logic [`PMP_XLEN-1:0] cfg_addr_before,  // previous pmpaddr, TOR bottom
  output logic                 match             // address falls in the entry
);

  import pmp_pkg::*;

  localparam int GRAN_BITS = (`PMP_GRAN == 0) ? 1 : `PMP_GRAN;
  localparam int GRAN_LSB  = GRAN_BITS - 1;            // lowest zero-bit position
  localparam int N_SIZES   = `PMP_XLEN - GRAN_LSB - 1; // region sizes below full space

  logic [N_SIZES+1:0] napot_hit;                       // one per region size
  logic               tor_hit;

  // a region of size 2^(z+3) bytes: bit z of cfg_addr is zero, bits below are ones
  for (genvar i = 0; i < N_SIZES; i++) begin : g_napot
    localparam int Z = i + GRAN_LSB;
    localparam logic [`PMP_XLEN-1:0] PATTERN = ~(`PMP_XLEN'(1) << Z);

    assign napot_hit[i] = (cfg_addr[Z:0] == PATTERN[Z:0]) &&
                          (phys_addr[`PMP_XLEN-1:Z+1] == cfg_addr[`PMP_XLEN-1:Z+1]);
  end

  // top bit clear with all ones below, or all ones: the whole address space
  assign napot_hit[N_SIZES]   = cfg_addr == {1'b0, {(`PMP_XLEN-1){1'b1}}};
  assign napot_hit[N_SIZES+1] = &cfg_addr;

  // empty or inverted range never hits
  assign tor_hit = (cfg_addr_before < cfg_addr) &&
                   (phys_addr >= cfg_addr_before) &&
                   (phys_addr < cfg_addr);

  always_comb begin
    case (check_cfg.a)
      NA4:     match = phys_addr == cfg_addr;          // exact word
      TOR:     match = tor_hit;
      NAPOT:   match = |napot_hit;                     // only one size can be encoded
      default: match = 1'b0;                           // OFF
    endcase
  end

endmodule

`default_nettype wire

/* design/pmp_check/pmp_check.sv */
`default_nettype none
`timescale 1ns/10ps
`include "pmp_cfg.svh"

module pmp_check (
  input  logic                 clk,
  input  logic                 rst,
  input  pmp_pkg::pmp_cfg_t    entry_cfg  [`PMP_ENTRIES],  // from register block
  input  logic [`PMP_XLEN-1:0] entry_addr [`PMP_ENTRIES],
  input  logic                 req_valid,
  input  logic [`PMP_XLEN-1:0] req_addr,                   // already >> 2
  input  pmp_pkg::priv_e       req_priv,
  input  pmp_pkg::access_e     req_access,
  output logic                 resp_valid,
  output logic                 resp_fault
);

  import pmp_pkg::*;

  logic [`PMP_ENTRIES-1:0] hit;                            // per-entry match
  logic [`PMP_XLEN-1:0]    addr_before [`PMP_ENTRIES];     // TOR bottom per entry
  logic                    found;
  pmp_cfg_t                sel_cfg;                        // winning entry's cfg
  logic                    perm;
  logic                    fault;

  for (genvar g = 0; g < `PMP_ENTRIES; g++) begin : g_entry
    if (g == 0) begin : g_first
      assign addr_before[g] = '0;                          // entry 0 ranges from zero
    end else begin : g_rest
      assign addr_before[g] = entry_addr[g-1];
    end

    pmp_matcher u_matcher (
      .phys_addr       (req_addr),
      .check_cfg       (entry_cfg[g]),
      .cfg_addr        (entry_addr[g]),
      .cfg_addr_before (addr_before[g]),
      .match           (hit[g])
    );
  end

  // scan downward so the lowest index wins
  always_comb begin
    found   = 1'b0;
    sel_cfg = '0;
    for (int i = `PMP_ENTRIES - 1; i >= 0; i--) begin
      if (hit[i]) begin
        found   = 1'b1;
        sel_cfg = entry_cfg[i];
      end
    end
  end

  always_comb begin
    case (req_access)
      ACC_READ:  perm = sel_cfg.r;
      ACC_WRITE: perm = sel_cfg.w;
      ACC_EXEC:  perm = sel_cfg.x;
      default:   perm = 1'b0;                              // unused opcode, deny
    endcase
  end

  // M-mode only bound by locked entries; anything else treated as user
  always_comb begin
    if (!found)
      fault = req_priv != PRIV_M;                          // default deny for U
    else if (req_priv == PRIV_M)
      fault = sel_cfg.l && !perm;
    else
      fault = !perm;
  end

  always_ff @(posedge clk) begin
    if (rst)
      resp_valid <= 1'b0;
    else
      resp_valid <= req_valid;                             // fixed one-cycle latency
  end

  always_ff @(posedge clk) begin
    if (req_valid)
      resp_fault <= fault;
  end

endmodule

`default_nettype wire

/* design/pmp_regs/pmp_regs.sv */
`default_nettype none
`timescale 1ns/10ps
`include "pmp_cfg.svh"

module pmp_regs (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [`PMP_XLEN-1:0]     awaddr,
  input  logic                     awvalid,
  output logic                     awready,
  input  logic [`PMP_XLEN-1:0]     wdata,
  input  logic [`PMP_XLEN/8-1:0]   wstrb,
  input  logic                     wvalid,
  output logic                     wready,
  output pmp_pkg::axi_resp_e       bresp,
  output logic                     bvalid,
  input  logic                     bready,
  input  logic [`PMP_XLEN-1:0]     araddr,
  input  logic                     arvalid,
  output logic                     arready,
  output logic [`PMP_XLEN-1:0]     rdata,
  output pmp_pkg::axi_resp_e       rresp,
  output logic                     rvalid,
  input  logic                     rready,
  output pmp_pkg::pmp_cfg_t        entry_cfg  [`PMP_ENTRIES],  // live pmpcfg bytes
  output logic [`PMP_XLEN-1:0]     entry_addr [`PMP_ENTRIES]   // live pmpaddr values
);

  import pmp_pkg::*;

  localparam int IDX_W = $clog2(`PMP_ENTRIES);
  localparam int NBYTE = `PMP_XLEN / 8;

  logic                    wr_en;
  logic                    rd_en;
  logic [`PMP_XLEN-1:0]    wr_cfg_off, wr_addr_off;      // offsets into each region
  logic [`PMP_XLEN-1:0]    rd_cfg_off, rd_addr_off;
  logic                    wr_cfg_hit, wr_addr_hit;
  logic                    rd_cfg_hit, rd_addr_hit;
  logic [IDX_W-1:0]        wr_idx, rd_idx;               // pmpaddr entry number
  logic [`PMP_ENTRIES-1:0] addr_locked;
  logic [`PMP_XLEN-1:0]    rd_data;

  // entry number of byte k in the cfg word at byte offset off
  function automatic logic [IDX_W-1:0] cfg_entry(input logic [`PMP_XLEN-1:0] off,
                                                 input int k);
    return (off[IDX_W-1:0] & ~IDX_W'(3)) | IDX_W'(k);
  endfunction

  // W without R is reserved
  function automatic pmp_cfg_t legal_cfg(input logic [7:0] b);
    pmp_cfg_t c;
    c = pmp_cfg_t'(b);
    if (!c.r)
      c.w = 1'b0;
    return c;
  endfunction

  // region decode, wrap-around on subtract keeps it one compare
  assign wr_cfg_off  = awaddr - `PMP_CFG_BASE;
  assign wr_addr_off = awaddr - `PMP_ADDR_BASE;
  assign rd_cfg_off  = araddr - `PMP_CFG_BASE;
  assign rd_addr_off = araddr - `PMP_ADDR_BASE;
  assign wr_cfg_hit  = wr_cfg_off < `PMP_XLEN'(`PMP_ENTRIES);       // one byte per entry
  assign wr_addr_hit = wr_addr_off < `PMP_XLEN'(4 * `PMP_ENTRIES);  // one word per entry
  assign rd_cfg_hit  = rd_cfg_off < `PMP_XLEN'(`PMP_ENTRIES);
  assign rd_addr_hit = rd_addr_off < `PMP_XLEN'(4 * `PMP_ENTRIES);
  assign wr_idx      = wr_addr_off[IDX_W+1:2];
  assign rd_idx      = rd_addr_off[IDX_W+1:2];

  assign wr_en   = awvalid && wvalid && !bvalid;         // both channels, no pending B
  assign awready = wr_en;
  assign wready  = wr_en;
  assign arready = !rvalid;
  assign rd_en   = arvalid && arready;

  // own lock, or the entry above is a locked TOR using this as its bottom
  always_comb begin
    for (int i = 0; i < `PMP_ENTRIES; i++)
      addr_locked[i] = entry_cfg[i].l;
    for (int i = 0; i < `PMP_ENTRIES - 1; i++)
      if (entry_cfg[i+1].l && entry_cfg[i+1].a == TOR)
        addr_locked[i] = 1'b1;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      bvalid <= 1'b0;
      for (int i = 0; i < `PMP_ENTRIES; i++) begin
        entry_cfg[i]  <= '0;                             // all entries OFF
        entry_addr[i] <= '0;
      end
    end else if (wr_en) begin
      bvalid <= 1'b1;
      if (wr_cfg_hit)
        for (int k = 0; k < NBYTE; k++)
          if (wstrb[k] && !entry_cfg[cfg_entry(wr_cfg_off, k)].l)
            entry_cfg[cfg_entry(wr_cfg_off, k)] <= legal_cfg(wdata[8*k +: 8]);
      if (wr_addr_hit && !addr_locked[wr_idx])
        for (int k = 0; k < NBYTE; k++)
          if (wstrb[k])
            entry_addr[wr_idx][8*k +: 8] <= wdata[8*k +: 8];
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  // locked writes are silently dropped, still OKAY
  always_ff @(posedge clk) begin
    if (wr_en)
      bresp <= (wr_cfg_hit || wr_addr_hit) ? RESP_OKAY : RESP_SLVERR;
  end

  always_comb begin
    rd_data = '0;                                        // unmapped reads zero
    if (rd_cfg_hit)
      for (int k = 0; k < NBYTE; k++)
        rd_data[8*k +: 8] = entry_cfg[cfg_entry(rd_cfg_off, k)];
    else if (rd_addr_hit)
      rd_data = entry_addr[rd_idx];
  end

  always_ff @(posedge clk) begin
    if (rst)
      rvalid <= 1'b0;
    else if (rd_en)
      rvalid <= 1'b1;
    else if (rready)
      rvalid <= 1'b0;                                    // held until taken
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rdata <= rd_data;
      rresp <= (rd_cfg_hit || rd_addr_hit) ? RESP_OKAY : RESP_SLVERR;
    end
  end

endmodule

`default_nettype wire

/* design/pmp_unit.sv */
`default_nettype none
`timescale 1ns/10ps
`include "pmp_cfg.svh"

module pmp_unit (
  input  logic                   clk,
  input  logic                   rst,
  // AXI4-Lite register port
  input  logic [`PMP_XLEN-1:0]   awaddr,
  input  logic                   awvalid,
  output logic                   awready,
  input  logic [`PMP_XLEN-1:0]   wdata,
  input  logic [`PMP_XLEN/8-1:0] wstrb,
  input  logic                   wvalid,
  output logic                   wready,
  output pmp_pkg::axi_resp_e     bresp,
  output logic                   bvalid,
  input  logic                   bready,
  input  logic [`PMP_XLEN-1:0]   araddr,
  input  logic                   arvalid,
  output logic                   arready,
  output logic [`PMP_XLEN-1:0]   rdata,
  output pmp_pkg::axi_resp_e     rresp,
  output logic                   rvalid,
  input  logic                   rready,
  // check port
  input  logic                   req_valid,
  input  logic [`PMP_XLEN-1:0]   req_addr,     // word address
  input  pmp_pkg::priv_e         req_priv,
  input  pmp_pkg::access_e       req_access,
  output logic                   resp_valid,   // one cycle after req_valid
  output logic                   resp_fault
);

  import pmp_pkg::*;

  pmp_cfg_t             entry_cfg  [`PMP_ENTRIES];  // regs -> checker
  logic [`PMP_XLEN-1:0] entry_addr [`PMP_ENTRIES];

  pmp_regs u_regs (
    .clk        (clk),
    .rst        (rst),
    .awaddr     (awaddr),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .wvalid     (wvalid),
    .wready     (wready),
    .bresp      (bresp),
    .bvalid     (bvalid),
    .bready     (bready),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata      (rdata),
    .rresp      (rresp),
    .rvalid     (rvalid),
    .rready     (rready),
    .entry_cfg  (entry_cfg),
    .entry_addr (entry_addr)
  );

  pmp_check u_check (
    .clk        (clk),
    .rst        (rst),
    .entry_cfg  (entry_cfg),
    .entry_addr (entry_addr),
    .req_valid  (req_valid),
    .req_addr   (req_addr),
    .req_priv   (req_priv),
    .req_access (req_access),
    .resp_valid (resp_valid),
    .resp_fault (resp_fault)
  );

endmodule

`default_nettype wire

/* verification/pmp_unit_tb.sv */
`default_nettype none
`timescale 1ns/10ps
`include "pmp_cfg.svh"

module pmp_unit_tb;

  import pmp_pkg::*;

  localparam int N          = `PMP_ENTRIES;
  localparam int ROUNDS     = 2000;
  localparam int MAX_CYCLES = ROUNDS * 40 + 5000;  // worst random round ~40 cycles

  logic                clk;
  logic                rst;
  logic [31:0]         awaddr;
  logic                awvalid;
  logic                awready;
  logic [31:0]         wdata;
  logic [3:0]          wstrb;
  logic                wvalid;
  logic                wready;
  axi_resp_e           bresp;
  logic                bvalid;
  logic                bready;
  logic [31:0]         araddr;
  logic                arvalid;
  logic                arready;
  logic [31:0]         rdata;
  axi_resp_e           rresp;
  logic                rvalid;
  logic                rready;
  logic                req_valid;
  logic [31:0]         req_addr;
  priv_e               req_priv;
  access_e             req_access;
  logic                resp_valid;
  logic                resp_fault;

  logic [7:0]          cfg_m [N];                  // register mirror
  logic [31:0]         addr_m [N];
  bit                  exp_q [$];                  // expected faults in flight
  bit                  exp_f;                      // head of queue at compare
  int                  errors = 0;
  int                  cycles = 0;
  int                  seed = 32'ha2a3;
  bit                  bp_en = 0;                  // random bready/rready when set
  logic [31:0]         rnd;
  logic [31:0]         probes [14] = '{32'hFF, 32'h100, 32'h101, 32'h14F, 32'h150, 32'h1FF,
                                       32'h200, 32'h3FF, 32'h400, 32'h807, 32'h808, 32'h80F,
                                       32'h810, 32'hFFFF_FFFF};

  pmp_unit u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // walk entries from 0, first hit decides
  function automatic bit ref_fault(input logic [31:0] a, input priv_e p, input access_e acc);
    logic [31:0] lo;
    logic [63:0] mask;
    logic [7:0]  c;
    bit          hit;
    bit          perm;
    int          t;
    for (int i = 0; i < N; i++) begin
      c  = cfg_m[i];
      lo = (i == 0) ? 32'h0 : addr_m[i-1];
      case (c[4:3])
        2'd1: hit = lo < addr_m[i] && a >= lo && a < addr_m[i];  // TOR
        2'd2: hit = a == addr_m[i];                              // NA4
        2'd3: begin                                              // NAPOT
          t = 0;
          while (t < 32 && addr_m[i][t])
            t++;
          mask = ~64'h0 << (t + 1);                              // region of 2^(t+1) words
          hit  = ({32'h0, a} & mask) == ({32'h0, addr_m[i]} & mask);
        end
        default: hit = 1'b0;
      endcase
      if (hit) begin
        perm = (acc == ACC_READ) ? c[0] : (acc == ACC_WRITE) ? c[1] : c[2];
        if (p == PRIV_M)
          return c[7] && !perm;
        return !perm;
      end
    end
    return p != PRIV_M;
  endfunction

  // {slverr, data} as the register map predicts
  function automatic logic [32:0] exp_read(input logic [31:0] a);
    if (a < 32'h8)
      return {1'b0, cfg_m[a[2]*4+3], cfg_m[a[2]*4+2], cfg_m[a[2]*4+1], cfg_m[a[2]*4]};
    if (a >= 32'h10 && a < 32'h30)
      return {1'b0, addr_m[int'((a - 32'h10) >> 2)]};
    return {1'b1, 32'h0};
  endfunction

  function automatic bit ready_pick();
    logic [31:0] r;
    r = $random(seed);
    return !bp_en || r[1:0] != 2'b00;                 // low a quarter of the time
  endfunction

  task automatic mirror_write(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s);
    int  e;
    bit  prot;
    if (a < 32'h8) begin
      for (int k = 0; k < 4; k++) begin
        e = a[2] * 4 + k;
        if (s[k] && !cfg_m[e][7]) begin
          cfg_m[e] = d[8*k +: 8];
          if (!cfg_m[e][0])
            cfg_m[e][1] = 1'b0;                       // W without R is reserved
        end
      end
    end else if (a >= 32'h10 && a < 32'h30) begin
      e    = int'((a - 32'h10) >> 2);
      prot = cfg_m[e][7] || (e < N - 1 && cfg_m[e+1][7] && cfg_m[e+1][4:3] == 2'd1);
      for (int k = 0; k < 4; k++)
        if (s[k] && !prot)
          addr_m[e][8*k +: 8] = d[8*k +: 8];
    end
  endtask

  task automatic axi_write(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s);
    logic [32:0] exp;
    exp = exp_read(a);
    mirror_write(a, d, s);
    @(posedge clk);
    awaddr  <= a;
    wdata   <= d;
    wstrb   <= s;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    bready  <= ready_pick();
    do @(posedge clk); while (!awready);
    if (!wready) begin
      errors++;
      $display("CHECK FAILED @%0t: write %h wready low with awready high", $time, a);
    end
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    forever begin
      @(posedge clk);
      if (bvalid && bready)
        break;
      bready <= ready_pick();
    end
    if ((bresp == RESP_SLVERR) != exp[32]) begin
      errors++;
      $display("CHECK FAILED @%0t: write %h bresp %0d", $time, a, bresp);
    end
  endtask

  task automatic axi_read(input logic [31:0] a);
    logic [32:0] exp;
    exp = exp_read(a);
    @(posedge clk);
    araddr  <= a;
    arvalid <= 1'b1;
    rready  <= ready_pick();
    do @(posedge clk); while (!arready);
    arvalid <= 1'b0;
    forever begin
      @(posedge clk);
      if (rvalid && rready)
        break;
      rready <= ready_pick();
    end
    if (rdata !== exp[31:0] || (rresp == RESP_SLVERR) != exp[32]) begin
      errors++;
      $display("CHECK FAILED @%0t: read %h got %h/%0d expected %h/%0d",
               $time, a, rdata, rresp, exp[31:0], exp[32]);
    end
  endtask

  task automatic verify_all();
    axi_read(32'h0);
    axi_read(32'h4);
    for (int i = 0; i < N; i++)
      axi_read(32'h10 + 32'(4 * i));
  endtask

  task automatic send_req(input logic [31:0] a, input priv_e p, input access_e acc);
    @(posedge clk);
    req_valid  <= 1'b1;
    req_addr   <= a;
    req_priv   <= p;
    req_access <= acc;
    exp_q.push_back(ref_fault(a, p, acc));
  endtask

  // six back-to-back checks per probe address
  task automatic probe_all();
    for (int i = 0; i < 14; i++)
      for (int j = 0; j < 3; j++) begin
        send_req(probes[i], PRIV_U, access_e'(j));
        send_req(probes[i], PRIV_M, access_e'(j));
      end
    @(posedge clk);
    req_valid <= 1'b0;
  endtask

  task automatic reset_dut();
    repeat (3) @(posedge clk);                        // let responses drain
    rst <= 1'b1;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < N; i++) begin
      cfg_m[i]  = 8'h0;
      addr_m[i] = 32'h0;
    end
  endtask

  always @(posedge clk) begin
    if (!rst && resp_valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("response arrived at %0t with no request outstanding", $time);
      end else begin
        exp_f = exp_q.pop_front();
        if (resp_fault !== exp_f) begin
          errors++;
          $display("CHECK FAILED @%0t: fault %0b expected %0b", $time, resp_fault, exp_f);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("** FAIL **");
      $finish;
    end
  end

  initial begin
    {awaddr, awvalid, wdata, wstrb, wvalid, bready} <= '0;
    {araddr, arvalid, rready, req_valid, req_addr} <= '0;
    req_priv   <= PRIV_U;
    req_access <= ACC_READ;
    rst        <= 1'b1;
    reset_dut();
    axi_write(32'h0, 32'h1F02_0D0B, 4'hF);           // byte 2 has W without R
    axi_write(32'h4, 32'hAB12_CD07, 4'b0101);
    axi_write(32'h14, 32'hDEAD_BEEF, 4'b0011);
    axi_write(32'h2C, 32'h1234_5678, 4'hF);
    verify_all();
    axi_write(32'h30, 32'h1, 4'hF);                  // unmapped
    axi_read(32'h8);
    axi_read(32'h40);
    reset_dut();
    axi_write(32'h10, 32'h100, 4'hF);                // NA4 word
    axi_write(32'h14, 32'h200, 4'hF);                // TOR 0x100..0x1FF
    axi_write(32'h18, 32'h150, 4'hF);                // inverted TOR, never hits
    axi_write(32'h1C, 32'h3FF, 4'hF);                // NAPOT 0..0x7FF
    axi_write(32'h20, 32'h80B, 4'hF);                // NAPOT 0x808..0x80F
    axi_write(32'h24, 32'hFFFF_FFFF, 4'hF);          // whole space
    axi_write(32'h0, 32'h1C0C_0B11, 4'hF);
    axi_write(32'h4, 32'h0000_191B, 4'hF);
    probe_all();
    axi_write(32'h4, 32'h0, 4'b0010);                // entry 5 off, misses now possible
    probe_all();
    axi_write(32'h0, 32'h91, 4'b0001);               // lock NA4 entry 0
    probe_all();
    axi_write(32'h0, 32'h07, 4'b0001);
    axi_write(32'h10, 32'h555, 4'hF);
    axi_write(32'h0, 32'h008F_0000, 4'b0100);        // locked TOR on entry 2
    axi_write(32'h14, 32'h999, 4'hF);                // guarded by entry 2
    verify_all();
    probe_all();
    reset_dut();
    bp_en = 1;
    for (int r = 0; r < ROUNDS; r++) begin
      if (r % 250 == 249)
        reset_dut();                                 // clear accumulated locks
      rnd = $random(seed);
      if (rnd[0])
        axi_write({29'h0, rnd[1], 2'b00}, $random(seed) & (rnd[7:4] == 0 ? 32'hFFFF_FFFF :
                  32'h7F7F_7F7F), rnd[11:8]);
      else
        axi_write(32'h10 + {27'h0, rnd[3:1], 2'b00}, $random(seed) & (rnd[7:4] == 0 ?
                  32'hFFFF_FFFF : 32'h0000_0FFF), rnd[11:8]);
      axi_read(rnd[12] ? {29'h0, rnd[13], 2'b00} : 32'h10 + {27'h0, rnd[15:13], 2'b00});
      for (int j = 0; j < 4; j++) begin
        rnd = $random(seed);
        send_req(addr_m[rnd[2:0]] + {{30{rnd[4]}}, rnd[4:3]}, rnd[5] ? PRIV_M : PRIV_U,
                 access_e'(rnd[7:6] == 2'd3 ? 2'd0 : rnd[7:6]));
      end
      @(posedge clk);
      req_valid <= 1'b0;
    end
    repeat (4) @(posedge clk);
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d check responses never arrived", exp_q.size());
    end
    $display("errors: %0d", errors);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

/* pmp_unit.f */
+incdir+common
common/pmp_pkg.sv
design/pmp_check/pmp_matcher.sv
design/pmp_check/pmp_check.sv
design/pmp_regs/pmp_regs.sv
design/pmp_unit.sv
verification/pmp_unit_tb.sv

/* Makefile */
TOP = pmp_unit_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qF '** PASS **'

obj_dir/V$(TOP): pmp_unit.f common/pmp_cfg.svh common/*.sv design/*.sv design/*/*.sv verification/*.sv
	verilator --binary --timing --top-module $(TOP) -f pmp_unit.f

lint:
	verilator --lint-only --timing --top-module $(TOP) -f pmp_unit.f

clean:
	rm -rf obj_dir
